// ==== common/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// register and datapath width
`define RV_XLEN 32

// register index width
`define RV_REG_ADDR_W 5

// architectural registers, x0 included
`define RV_NUM_REGS 32

// first fetch address
`define RV_RESET_PC 32'h0000_0000

// fall-through pc step
`define RV_INSN_BYTES 4

`endif

// ==== common/rv_pkg.sv ====
package rv_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // low three bits follow funct3, bit 3 is the funct7 alternate bit
  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_SLL    = 4'b0001,
    ALU_SLT    = 4'b0010,
    ALU_SLTU   = 4'b0011,
    ALU_XOR    = 4'b0100,
    ALU_SRL    = 4'b0101,
    ALU_OR     = 4'b0110,
    ALU_AND    = 4'b0111,
    ALU_SUB    = 4'b1000,
    ALU_SRA    = 4'b1101,
    // operand b straight through, for lui
    ALU_PASS_B = 4'b1111
  } alu_op_e;

  // branch funct3 encodings
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

endpackage

// ==== src/rv_decode.sv ====
`timescale 1ns/1ns

`include "rv_params.svh"

module rv_decode (
  input  logic [`RV_XLEN-1:0]       insn,
  output logic [`RV_REG_ADDR_W-1:0] rs1,
  output logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic [`RV_REG_ADDR_W-1:0] rd,
  output logic [`RV_XLEN-1:0]       imm,
  output rv_pkg::alu_op_e           alu_op,
  output rv_pkg::br_cond_e          br_cond,
  output logic                      use_imm,
  output logic                      is_branch,
  output logic                      writes_rd,
  output logic                      halt,
  output logic                      illegal
);

  rv_pkg::opcode_e     opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                funct7_zero;
  logic                funct7_alt;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;

  // fixed field positions
  assign opcode = rv_pkg::opcode_e'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  assign funct7_zero = (funct7 == 7'b0000000);
  assign funct7_alt  = (funct7 == 7'b0100000);

  // sign-extended immediates, shamt sits in the low bits of imm_i
  assign imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_b = {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    imm       = '0;
    alu_op    = rv_pkg::ALU_ADD;
    br_cond   = rv_pkg::br_cond_e'(funct3);
    use_imm   = 1'b0;
    is_branch = 1'b0;
    writes_rd = 1'b0;
    halt      = 1'b0;
    illegal   = 1'b0;

    case (opcode)
      rv_pkg::OPC_LUI: begin
        imm       = imm_u;
        alu_op    = rv_pkg::ALU_PASS_B;
        use_imm   = 1'b1;
        writes_rd = 1'b1;
      end

      rv_pkg::OPC_OP_IMM: begin
        imm       = imm_i;
        use_imm   = 1'b1;
        writes_rd = 1'b1;
        alu_op    = rv_pkg::alu_op_e'({1'b0, funct3});
        // shifts reuse the upper immediate bits as funct7
        if (funct3 == 3'b001 && !funct7_zero) begin
          illegal = 1'b1;
        end else if (funct3 == 3'b101) begin
          if (funct7_alt) begin
            alu_op = rv_pkg::ALU_SRA;
          end else if (!funct7_zero) begin
            illegal = 1'b1;
          end
        end
      end

      rv_pkg::OPC_OP: begin
        writes_rd = 1'b1;
        alu_op    = rv_pkg::alu_op_e'({funct7[5], funct3});
        // only add/sub and srl/sra have an alternate form
        if (!(funct7_zero || (funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
          illegal = 1'b1;
        end
      end

      rv_pkg::OPC_BRANCH: begin
        imm       = imm_b;
        is_branch = 1'b1;
        // funct3 010 and 011 are reserved
        if (funct3[2:1] == 2'b01) begin
          illegal = 1'b1;
        end
      end

      rv_pkg::OPC_SYSTEM: begin
        if (insn[31:7] == 25'd0) begin
          halt = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end

      default: begin
        illegal = 1'b1;
      end
    endcase

    // nothing retires from an illegal encoding
    if (illegal) begin
      writes_rd = 1'b0;
      is_branch = 1'b0;
    end
  end

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ns

`include "rv_params.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`RV_REG_ADDR_W-1:0] rs1,
  input  logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data,
  input  logic                      wb_en,
  input  logic [`RV_REG_ADDR_W-1:0] wb_rd,
  input  logic [`RV_XLEN-1:0]       wb_data
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_rd] <= wb_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/1ns

`include "rv_params.svh"

module rv_execute (
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic [`RV_XLEN-1:0] imm,
  input  rv_pkg::alu_op_e     alu_op,
  input  rv_pkg::br_cond_e    br_cond,
  input  logic                use_imm,
  input  logic                is_branch,
  output logic [`RV_XLEN-1:0] alu_result,
  output logic                br_taken
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0] op_b;
  logic [SHAMT_W-1:0]  shamt;
  logic                alu_lt;
  logic                alu_ltu;
  logic                br_eq;
  logic                br_lt;
  logic                br_ltu;
  logic                cond_met;

  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[SHAMT_W-1:0];

  // slt/sltu compare against operand b, branches against rs2
  assign alu_lt  = $signed(rs1_data) < $signed(op_b);
  assign alu_ltu = rs1_data < op_b;
  assign br_eq   = rs1_data == rs2_data;
  assign br_lt   = $signed(rs1_data) < $signed(rs2_data);
  assign br_ltu  = rs1_data < rs2_data;

  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD:    alu_result = rs1_data + op_b;
      rv_pkg::ALU_SUB:    alu_result = rs1_data - op_b;
      rv_pkg::ALU_SLL:    alu_result = rs1_data << shamt;
      rv_pkg::ALU_SLT:    alu_result = {{(`RV_XLEN-1){1'b0}}, alu_lt};
      rv_pkg::ALU_SLTU:   alu_result = {{(`RV_XLEN-1){1'b0}}, alu_ltu};
      rv_pkg::ALU_XOR:    alu_result = rs1_data ^ op_b;
      rv_pkg::ALU_SRL:    alu_result = rs1_data >> shamt;
      rv_pkg::ALU_SRA:    alu_result = $signed(rs1_data) >>> shamt;
      rv_pkg::ALU_OR:     alu_result = rs1_data | op_b;
      rv_pkg::ALU_AND:    alu_result = rs1_data & op_b;
      rv_pkg::ALU_PASS_B: alu_result = op_b;
      default:            alu_result = '0;
    endcase
  end

  always_comb begin
    case (br_cond)
      rv_pkg::BR_EQ:  cond_met = br_eq;
      rv_pkg::BR_NE:  cond_met = !br_eq;
      rv_pkg::BR_LT:  cond_met = br_lt;
      rv_pkg::BR_GE:  cond_met = !br_lt;
      rv_pkg::BR_LTU: cond_met = br_ltu;
      rv_pkg::BR_GEU: cond_met = !br_ltu;
      default:        cond_met = 1'b0;
    endcase
  end

  // br_cond is garbage outside branches
  assign br_taken = is_branch && cond_met;

endmodule

// ==== src/rv_result.sv ====
`timescale 1ns/1ns

`include "rv_params.svh"

module rv_result (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`RV_XLEN-1:0]       alu_result,
  input  logic [`RV_XLEN-1:0]       imm,
  input  logic                      br_taken,
  input  logic                      writes_rd,
  input  logic                      halt,
  input  logic                      illegal,
  input  logic [`RV_REG_ADDR_W-1:0] rd,
  output logic [`RV_XLEN-1:0]       pc,
  output logic                      wb_en,
  output logic [`RV_REG_ADDR_W-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]       wb_data
);

  logic [`RV_XLEN-1:0] pc_next;

  // core parks on halt or illegal until reset
  always_comb begin
    if (halt || illegal) begin
      pc_next = pc;
    end else if (br_taken) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc + `RV_INSN_BYTES;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // x0 writes are dropped here
  assign wb_en   = writes_rd && (rd != '0) && !rst;
  assign wb_rd   = rd;
  assign wb_data = alu_result;

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ns

`include "rv_params.svh"

module rv_core (
  input  logic                      clk,
  input  logic                      rst,
  output logic [`RV_XLEN-1:0]       pc,
  input  logic [`RV_XLEN-1:0]       insn,
  output logic                      wb_en,
  output logic [`RV_REG_ADDR_W-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]       wb_data,
  output logic                      halt,
  output logic                      illegal
);

  logic [`RV_REG_ADDR_W-1:0] rs1;
  logic [`RV_REG_ADDR_W-1:0] rs2;
  logic [`RV_REG_ADDR_W-1:0] rd;
  logic [`RV_XLEN-1:0]       imm;
  logic [`RV_XLEN-1:0]       rs1_data;
  logic [`RV_XLEN-1:0]       rs2_data;
  logic [`RV_XLEN-1:0]       alu_result;
  rv_pkg::alu_op_e           alu_op;
  rv_pkg::br_cond_e          br_cond;
  logic                      use_imm;
  logic                      is_branch;
  logic                      writes_rd;
  logic                      br_taken;

  rv_decode rv_decode_i (
    .insn      (insn),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .br_cond   (br_cond),
    .use_imm   (use_imm),
    .is_branch (is_branch),
    .writes_rd (writes_rd),
    .halt      (halt),
    .illegal   (illegal)
  );

  rv_regfile rv_regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  rv_execute rv_execute_i (
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .alu_op     (alu_op),
    .br_cond    (br_cond),
    .use_imm    (use_imm),
    .is_branch  (is_branch),
    .alu_result (alu_result),
    .br_taken   (br_taken)
  );

  rv_result rv_result_i (
    .clk        (clk),
    .rst        (rst),
    .alu_result (alu_result),
    .imm        (imm),
    .br_taken   (br_taken),
    .writes_rd  (writes_rd),
    .halt       (halt),
    .illegal    (illegal),
    .rd         (rd),
    .pc         (pc),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

endmodule

// ==== dv/rv_core_asserts.sv ====
`timescale 1ns/1ns

`include "rv_params.svh"

module rv_core_asserts (
  input logic                      clk,
  input logic                      rst,
  input logic [`RV_XLEN-1:0]       pc,
  input logic                      wb_en,
  input logic [`RV_REG_ADDR_W-1:0] wb_rd,
  input logic                      halt,
  input logic                      illegal
);

  wb_off_in_rst: assert property (@(posedge clk) rst |-> !wb_en)
    else $error("register write enabled during reset");

  // x0 is never a write target
  no_x0_write: assert property (@(posedge clk) wb_en |-> (wb_rd != '0))
    else $error("write-back to register zero");

  // parked core keeps its pc
  pc_parked: assert property (@(posedge clk) disable iff (rst)
                              (halt || illegal) |=> $stable(pc))
    else $error("pc moved while halted or illegal");

endmodule

bind rv_core rv_core_asserts rv_core_asserts_i (
  .clk     (clk),
  .rst     (rst),
  .pc      (pc),
  .wb_en   (wb_en),
  .wb_rd   (wb_rd),
  .halt    (halt),
  .illegal (illegal)
);

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/1ns

`include "rv_params.svh"

module rv_core_tb;

  localparam logic [31:0] ecall_insn = 32'h0000_0073;

  logic                      clk = 1'b0;
  logic                      rst = 1'b1;
  logic [`RV_XLEN-1:0]       pc;
  logic [`RV_XLEN-1:0]       insn;
  logic                      wb_en;
  logic [`RV_REG_ADDR_W-1:0] wb_rd;
  logic [`RV_XLEN-1:0]       wb_data;
  logic                      halt;
  logic                      illegal;

  logic [31:0] prog [128];
  int          plen;
  logic [31:0] mregs [32];
  logic [31:0] mpc;
  logic [31:0] lfsr = 32'hc46c3f26;
  int          cycles = 0;
  int          cycle_limit = 0;

  rv_core rv_core_i (
    .clk     (clk),
    .rst     (rst),
    .pc      (pc),
    .insn    (insn),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .halt    (halt),
    .illegal (illegal)
  );

  always #50 clk = ~clk;

  // instruction memory answers a nop until the pc is known
  assign insn = $isunknown(pc) ? 32'h0000_0013 : prog[pc[8:2]];

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("STATUS: FAIL");
      $fatal(1, "timeout: the run went past its cycle limit");
    end
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
  endfunction

  // rv32i alu rules with alt selecting sub and sra
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[plen] = w;
    plen++;
  endtask

  // lui then addi with the upper part rounded for the sign of the low part
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit({upper[31:12], rd, rv_pkg::OPC_LUI});
    emit(enc_i(rv_pkg::OPC_OP_IMM, 3'd0, rd, rd, value[11:0]));
  endtask

  task automatic compare(input string test, input string field,
                         input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s: %s expected %h actual %h", test, field, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "%s stopped at the first mismatch", test);
    end
  endtask

  // executes the instruction at the model pc against the model registers
  task automatic model_step(output logic en, output logic [4:0] rd, output logic [31:0] data,
                            output logic [31:0] npc, output logic hlt, output logic ill);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        take;
    w = prog[mpc[8:2]];
    f3 = w[14:12];
    f7 = w[31:25];
    rd = w[11:7];
    a = mregs[w[19:15]];
    b = mregs[w[24:20]];
    en = 1'b0;
    data = '0;
    hlt = 1'b0;
    ill = 1'b0;
    take = 1'b0;
    npc = mpc + `RV_INSN_BYTES;
    case (w[6:0])
      rv_pkg::OPC_LUI: begin
        en = 1'b1;
        data = {w[31:12], 12'd0};
      end
      rv_pkg::OPC_OP_IMM: begin
        if ((f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
          ill = 1'b1;
        end else begin
          en = 1'b1;
          data = alu_ref(f3, f3 == 3'd5 && f7 == 7'h20, a, {{20{w[31]}}, w[31:20]});
        end
      end
      rv_pkg::OPC_OP: begin
        if (f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          ill = 1'b1;
        end else begin
          en = 1'b1;
          data = alu_ref(f3, f7 == 7'h20, a, b);
        end
      end
      rv_pkg::OPC_BRANCH: begin
        case (f3)
          3'd0:    take = (a == b);
          3'd1:    take = (a != b);
          3'd4:    take = ($signed(a) < $signed(b));
          3'd5:    take = ($signed(a) >= $signed(b));
          3'd6:    take = (a < b);
          3'd7:    take = (a >= b);
          default: ill = 1'b1;
        endcase
        if (take) begin
          npc = mpc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      rv_pkg::OPC_SYSTEM: begin
        if (w[31:7] == 25'd0) begin
          hlt = 1'b1;
        end else begin
          ill = 1'b1;
        end
      end
      default: ill = 1'b1;
    endcase
    if (rd == 5'd0) begin
      en = 1'b0;
    end
    if (hlt || ill) begin
      npc = mpc;
    end
  endtask

  // resets the core and checks every cycle until a few cycles past the program
  task automatic run_program(input string name);
    logic        en;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] npc;
    logic        hlt;
    logic        ill;
    cycle_limit += 2 * plen + 4;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    mpc = `RV_RESET_PC;
    @(posedge clk);
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (plen + 3) begin
      @(negedge clk);
      model_step(en, rd, data, npc, hlt, ill);
      compare(name, "pc", mpc, pc);
      compare(name, "halt", 32'(hlt), 32'(halt));
      compare(name, "illegal", 32'(ill), 32'(illegal));
      compare(name, "wb_en", 32'(en), 32'(wb_en));
      if (en) begin
        compare(name, "wb_rd", 32'(rd), 32'(wb_rd));
        compare(name, "wb_data", data, wb_data);
        mregs[rd] = data;
      end
      mpc = npc;
    end
  endtask

  task automatic test_imm();
    logic [2:0]  f3s [9];
    logic [31:0] r;
    logic [31:0] v;
    logic [11:0] imm;
    f3s = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    plen = 0;
    for (int i = 0; i < 9; i++) begin
      v = rand_bits(32);
      // negative rs1 so srai and srli differ
      if (f3s[i] == 3'd5) begin
        v[31] = 1'b1;
      end
      load_reg(5'(i + 1), v);
      r = rand_bits(12);
      imm = r[11:0];
      // shift amount only with srai on the last slot
      if (f3s[i] == 3'd1 || f3s[i] == 3'd5) begin
        r = rand_bits(5);
        imm = {(i == 8) ? 7'h20 : 7'h00, r[4:0]};
      end
      emit(enc_i(rv_pkg::OPC_OP_IMM, f3s[i], 5'(i + 10), 5'(i + 1), imm));
    end
    emit(ecall_insn);
    run_program("imm_ops");
  endtask

  task automatic test_reg();
    logic [2:0]  f3s [10];
    logic [6:0]  f7s [10];
    logic [31:0] a;
    logic [31:0] b;
    f3s = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    f7s = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    plen = 0;
    for (int i = 0; i < 10; i++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      // negative rs1 on every other op and on both right shifts
      if (i % 2 == 0 || f3s[i] == 3'd5) begin
        a[31] = 1'b1;
      end
      // negative rs1 against positive rs2 tells slt from sltu
      if (f3s[i] == 3'd2 || f3s[i] == 3'd3) begin
        a[31] = 1'b1;
        b[31] = 1'b0;
      end
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      emit(enc_r(f7s[i], f3s[i], 5'(i + 3), 5'd1, 5'd2));
    end
    emit(ecall_insn);
    run_program("reg_ops");
  endtask

  task automatic test_x0();
    plen = 0;
    load_reg(5'd1, rand_bits(32));
    emit(enc_i(rv_pkg::OPC_OP_IMM, 3'd0, 5'd0, 5'd1, 12'd5));
    emit(enc_r(7'h00, 3'd0, 5'd2, 5'd0, 5'd1));
    emit(enc_r(7'h20, 3'd0, 5'd3, 5'd1, 5'd0));
    emit(ecall_insn);
    run_program("x0_reg");
  endtask

  task automatic test_branch();
    logic [2:0] conds [6];
    logic [4:0] lhs [3];
    logic [4:0] rhs [3];
    logic [31:0] v;
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    // equal pair, negative vs positive, positive vs negative
    lhs = '{5'd1, 5'd3, 5'd4};
    rhs = '{5'd2, 5'd4, 5'd3};
    plen = 0;
    v = rand_bits(32);
    load_reg(5'd1, v);
    load_reg(5'd2, v);
    load_reg(5'd3, 32'hffff_fffb);
    load_reg(5'd4, 32'd3);
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        emit(enc_b(conds[c], lhs[p], rhs[p], 13'd8));
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'd0, 5'd5, 5'd5, 12'd1));
        emit(enc_i(rv_pkg::OPC_OP_IMM, 3'd0, 5'd6, 5'd6, 12'd1));
      end
    end
    emit(ecall_insn);
    run_program("branches");
  endtask

  task automatic test_ecall();
    plen = 0;
    emit(enc_i(rv_pkg::OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'd7));
    emit(ecall_insn);
    emit(enc_i(rv_pkg::OPC_OP_IMM, 3'd0, 5'd2, 5'd0, 12'd9));
    run_program("ecall_halt");
  endtask

  task automatic test_illegal();
    plen = 0;
    emit(enc_i(rv_pkg::OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'd3));
    // lw x2, 0(x0)
    emit(enc_i(7'b0000011, 3'd2, 5'd2, 5'd0, 12'd0));
    emit(enc_i(rv_pkg::OPC_OP_IMM, 3'd0, 5'd3, 5'd0, 12'd1));
    run_program("illegal_load");
    plen = 0;
    emit(enc_i(rv_pkg::OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'd3));
    emit(enc_r(7'h01, 3'd0, 5'd2, 5'd1, 5'd1));
    emit(enc_i(rv_pkg::OPC_OP_IMM, 3'd0, 5'd3, 5'd0, 12'd1));
    run_program("illegal_funct7");
  endtask

  initial begin
    test_imm();
    test_reg();
    test_x0();
    test_branch();
    test_ecall();
    test_illegal();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== rv_core.f ====
+incdir+common
common/rv_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
dv/rv_core_asserts.sv
dv/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the rv_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb \
    -o rv_core_sim; then
  echo "build failed" >&2
  exit 1
fi

if ! ./obj_dir/rv_core_sim; then
  echo "simulation failed" >&2
  exit 1
fi

exit 0
